// ==== design/snake_vga_pkg.sv ====
package snake_vga_pkg;

	// Position being drawn as registered by the timing block.
	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
		logic active;
	} pixel_pos_t;

	typedef logic [15:0] rgb565_t;

	// Tile contents reported by the game logic.
	typedef enum logic [1:0] {
		cell_empty = 2'b00,
		cell_head = 2'b01,
		cell_body = 2'b10,
		cell_wall = 2'b11
	} cell_e;

	typedef struct packed {
		logic [3:0] hundreds;
		logic [3:0] tens;
		logic [3:0] units;
	} score_t;

	typedef logic [5:0] tile_x_t;
	typedef logic [4:0] tile_y_t;

	localparam rgb565_t color_black = 16'h0000;
	localparam rgb565_t color_food = 16'hff80;
	localparam rgb565_t color_head = 16'h80ff;
	localparam rgb565_t color_body = 16'h0480;
	localparam rgb565_t color_wall = 16'hff00;
	localparam rgb565_t color_digit = 16'h80ff;

	// Seven segment enables with top in the high bit.
	typedef logic [6:0] segments_t;

	localparam int seg_top = 6;
	localparam int seg_middle = 5;
	localparam int seg_bottom = 4;
	localparam int seg_upper_left = 3;
	localparam int seg_upper_right = 2;
	localparam int seg_lower_left = 1;
	localparam int seg_lower_right = 0;

endpackage

// ==== design/vga_timing.sv ====
`timescale 1ns/1ps

module vga_timing #(
	parameter int H_TOTAL = 800,
	parameter int H_SYNC = 96,
	parameter int H_OFFSET = 135,
	parameter int H_ACTIVE = 640,
	parameter int V_TOTAL = 525,
	parameter int V_SYNC = 2,
	parameter int V_OFFSET = 33,
	parameter int V_ACTIVE = 480
) (
	input logic clk,
	input logic rst,
	output logic hsync,
	output logic vsync,
	output snake_vga_pkg::pixel_pos_t pos
);
	import snake_vga_pkg::*;

	logic [9:0] h_cnt;
	logic [9:0] v_cnt;
	logic h_wrap;
	logic v_wrap;
	pixel_pos_t pos_next;

	assign h_wrap = (h_cnt == 10'(H_TOTAL - 1));
	assign v_wrap = (v_cnt == 10'(V_TOTAL - 1));

	// Line counter steps only at the end of a line.
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_wrap) begin
			h_cnt <= '0;
			if (v_wrap) begin
				v_cnt <= '0;
			end else begin
				v_cnt <= v_cnt + 10'd1;
			end
		end else begin
			h_cnt <= h_cnt + 10'd1;
		end
	end

	// Offsets wrap in ten bits, so the porches land above the active range.
	always_comb begin
		pos_next.x = h_cnt - 10'(H_OFFSET);
		pos_next.y = v_cnt - 10'(V_OFFSET);
		pos_next.active = (pos_next.x < 10'(H_ACTIVE)) && (pos_next.y < 10'(V_ACTIVE));
	end

	// Sync pulses and position leave in the same cycle.
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			hsync <= 1'b1;
			vsync <= 1'b1;
			pos <= '0;
		end else begin
			hsync <= (h_cnt >= 10'(H_SYNC));
			vsync <= (v_cnt >= 10'(V_SYNC));
			pos <= pos_next;
		end
	end

endmodule

// ==== design/cell_renderer.sv ====
`timescale 1ns/1ps

module cell_renderer (
	input snake_vga_pkg::pixel_pos_t pos,
	input snake_vga_pkg::cell_e snake,
	input snake_vga_pkg::tile_x_t food_x,
	input snake_vga_pkg::tile_y_t food_y,
	output snake_vga_pkg::rgb565_t field_rgb
);
	import snake_vga_pkg::*;

	tile_x_t tile_x;
	logic [5:0] tile_row;
	logic is_food;
	logic corner;

	assign tile_x = pos.x[9:4];
	// Rows past the playfield never match a five bit food row.
	assign tile_row = pos.y[9:4];

	assign is_food = (tile_x == food_x) && (tile_row == {1'b0, food_y});
	assign corner = (pos.x[3:0] == 4'd0) && (pos.y[3:0] == 4'd0);

	always_comb begin
		if (is_food) begin
			field_rgb = corner ? color_black : color_food;
		end else begin
			case (snake)
				cell_head: begin
					field_rgb = corner ? color_black : color_head;
				end
				cell_body: begin
					field_rgb = corner ? color_black : color_body;
				end
				// Walls are solid without a dot.
				cell_wall: begin
					field_rgb = color_wall;
				end
				default: begin
					field_rgb = color_black;
				end
			endcase
		end
	end

endmodule

// ==== design/digit_segments.sv ====
`timescale 1ns/1ps

module digit_segments (
	input logic [3:0] digit,
	output snake_vga_pkg::segments_t segments
);

	// Bit order is top, middle, bottom, upper left, upper right,
	// lower left, lower right.
	always_comb begin
		case (digit)
			4'd0: begin
				segments = 7'b1011111;
			end
			4'd1: begin
				segments = 7'b0000101;
			end
			4'd2: begin
				segments = 7'b1110110;
			end
			4'd3: begin
				segments = 7'b1110101;
			end
			4'd4: begin
				segments = 7'b0101101;
			end
			4'd5: begin
				segments = 7'b1111001;
			end
			4'd6: begin
				segments = 7'b1111011;
			end
			4'd7: begin
				segments = 7'b1000101;
			end
			4'd8: begin
				segments = 7'b1111111;
			end
			4'd9: begin
				segments = 7'b1111101;
			end
			// Values above nine stay blank.
			default: begin
				segments = 7'b0000000;
			end
		endcase
	end

endmodule

// ==== design/score_renderer.sv ====
`timescale 1ns/1ps

module score_renderer #(
	parameter int DIGIT_ORIGIN_0 = 6,
	parameter int DIGIT_ORIGIN_1 = 16,
	parameter int DIGIT_ORIGIN_2 = 26
) (
	input snake_vga_pkg::pixel_pos_t pos,
	input snake_vga_pkg::score_t score,
	output snake_vga_pkg::rgb565_t score_rgb
);
	import snake_vga_pkg::*;

	segments_t seg_hundreds;
	segments_t seg_tens;
	segments_t seg_units;
	segments_t seg_sel;
	segments_t seg_mask;
	logic [5:0] col;
	logic [5:0] row;
	logic [5:0] origin;
	logic [5:0] rel;
	logic in_glyph;
	logic left;
	logic right;

	digit_segments i_seg_hundreds (.digit(score.hundreds), .segments(seg_hundreds));
	digit_segments i_seg_tens (.digit(score.tens), .segments(seg_tens));
	digit_segments i_seg_units (.digit(score.units), .segments(seg_units));

	// Screen is laid out in 16 pixel blocks.
	assign col = pos.x[9:4];
	assign row = pos.y[9:4];

	always_comb begin
		if (col < 6'd15) begin
			seg_sel = seg_hundreds;
			origin = 6'(DIGIT_ORIGIN_0);
		end else if (col < 6'd25) begin
			seg_sel = seg_tens;
			origin = 6'(DIGIT_ORIGIN_1);
		end else begin
			seg_sel = seg_units;
			origin = 6'(DIGIT_ORIGIN_2);
		end
	end

	assign rel = col - origin;
	assign in_glyph = (col >= origin) && (rel < 6'd8);
	assign left = in_glyph && (rel < 6'd2);
	assign right = in_glyph && (rel >= 6'd6);

	// Blocks covered by each segment.
	// Vertical bars overlap the bars across.
	always_comb begin
		seg_mask[seg_top] = in_glyph && (row >= 6'd8) && (row <= 6'd9);
		seg_mask[seg_middle] = in_glyph && (row >= 6'd14) && (row <= 6'd15);
		seg_mask[seg_bottom] = in_glyph && (row >= 6'd20) && (row <= 6'd21);
		seg_mask[seg_upper_left] = left && (row >= 6'd8) && (row <= 6'd15);
		seg_mask[seg_upper_right] = right && (row >= 6'd8) && (row <= 6'd15);
		seg_mask[seg_lower_left] = left && (row >= 6'd14) && (row <= 6'd21);
		seg_mask[seg_lower_right] = right && (row >= 6'd14) && (row <= 6'd21);
	end

	assign score_rgb = (|(seg_sel & seg_mask)) ? color_digit : color_black;

endmodule

// ==== design/pixel_composer.sv ====
`timescale 1ns/1ps

module pixel_composer (
	input logic clk,
	input logic rst,
	input snake_vga_pkg::pixel_pos_t pos,
	input logic score_flag,
	input snake_vga_pkg::rgb565_t field_rgb,
	input snake_vga_pkg::rgb565_t score_rgb,
	output snake_vga_pkg::rgb565_t rgb
);
	import snake_vga_pkg::*;

	rgb565_t rgb_next;

	// Outside the visible area the DAC must see black.
	always_comb begin
		if (!pos.active) begin
			rgb_next = color_black;
		end else if (score_flag) begin
			rgb_next = score_rgb;
		end else begin
			rgb_next = field_rgb;
		end
	end

	// One cycle behind pos.
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rgb <= color_black;
		end else begin
			rgb <= rgb_next;
		end
	end

endmodule

// ==== design/snake_vga.sv ====
`timescale 1ns/1ps

module snake_vga #(
	parameter int H_TOTAL = 800,
	parameter int H_SYNC = 96,
	parameter int H_OFFSET = 135,
	parameter int H_ACTIVE = 640,
	parameter int V_TOTAL = 525,
	parameter int V_SYNC = 2,
	parameter int V_OFFSET = 33,
	parameter int V_ACTIVE = 480,
	parameter int DIGIT_ORIGIN_0 = 6,
	parameter int DIGIT_ORIGIN_1 = 16,
	parameter int DIGIT_ORIGIN_2 = 26
) (
	input logic clk,
	input logic rst,
	input snake_vga_pkg::score_t score,
	input logic score_flag,
	input snake_vga_pkg::cell_e snake,
	input snake_vga_pkg::tile_x_t food_x,
	input snake_vga_pkg::tile_y_t food_y,
	output logic [9:0] pos_x,
	output logic [9:0] pos_y,
	output logic hsync,
	output logic vsync,
	output snake_vga_pkg::rgb565_t rgb
);
	import snake_vga_pkg::*;

	pixel_pos_t pos;
	rgb565_t field_rgb;
	rgb565_t score_rgb;

	vga_timing #(
		.H_TOTAL(H_TOTAL),
		.H_SYNC(H_SYNC),
		.H_OFFSET(H_OFFSET),
		.H_ACTIVE(H_ACTIVE),
		.V_TOTAL(V_TOTAL),
		.V_SYNC(V_SYNC),
		.V_OFFSET(V_OFFSET),
		.V_ACTIVE(V_ACTIVE)
	) i_timing (
		.clk(clk),
		.rst(rst),
		.hsync(hsync),
		.vsync(vsync),
		.pos(pos)
	);

	cell_renderer i_cell (
		.pos(pos),
		.snake(snake),
		.food_x(food_x),
		.food_y(food_y),
		.field_rgb(field_rgb)
	);

	score_renderer #(
		.DIGIT_ORIGIN_0(DIGIT_ORIGIN_0),
		.DIGIT_ORIGIN_1(DIGIT_ORIGIN_1),
		.DIGIT_ORIGIN_2(DIGIT_ORIGIN_2)
	) i_score (
		.pos(pos),
		.score(score),
		.score_rgb(score_rgb)
	);

	pixel_composer i_composer (
		.clk(clk),
		.rst(rst),
		.pos(pos),
		.score_flag(score_flag),
		.field_rgb(field_rgb),
		.score_rgb(score_rgb),
		.rgb(rgb)
	);

	// Game logic answers snake for this position.
	assign pos_x = pos.x;
	assign pos_y = pos.y;

endmodule

// ==== sim/tb_snake_vga_tasks.svh ====
task automatic check(input string name, input int got, input int expected);
	if (got != expected) begin
		$display("Error: time %0t signal %s got 0x%0h expected 0x%0h",
			$time, name, got, expected);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at the first mismatch");
	end
endtask

// Segment order top, middle, bottom, upper left, upper right, lower left, lower right.
function automatic logic [6:0] glyph(input logic [3:0] digit);
	case (digit)
		4'd0: return 7'b1011111;
		4'd1: return 7'b0000101;
		4'd2: return 7'b1110110;
		4'd3: return 7'b1110101;
		4'd4: return 7'b0101101;
		4'd5: return 7'b1111001;
		4'd6: return 7'b1111011;
		4'd7: return 7'b1000101;
		4'd8: return 7'b1111111;
		4'd9: return 7'b1111101;
		default: return 7'b0000000;
	endcase
endfunction

function automatic bit digit_pixel(input int col, input int row, input score_t sc);
	logic [3:0] digit;
	logic [6:0] lit;
	int origin;
	int rel;
	bit left;
	bit right;
	if (col < 15) begin
		digit = sc.hundreds;
		origin = 6;
	end else if (col < 25) begin
		digit = sc.tens;
		origin = 16;
	end else begin
		digit = sc.units;
		origin = 26;
	end
	rel = col - origin;
	if (rel < 0 || rel > 7) begin
		return 1'b0;
	end
	lit = glyph(digit);
	left = (rel <= 1);
	right = (rel >= 6);
	return (lit[6] && row >= 8 && row <= 9) || (lit[5] && row >= 14 && row <= 15) ||
		(lit[4] && row >= 20 && row <= 21) || (lit[3] && left && row >= 8 && row <= 15) ||
		(lit[2] && right && row >= 8 && row <= 15) ||
		(lit[1] && left && row >= 14 && row <= 21) ||
		(lit[0] && right && row >= 14 && row <= 21);
endfunction

function automatic rgb565_t expected_rgb(input sample_t s);
	int x;
	int y;
	bit dot;
	x = int'(s.x);
	y = int'(s.y);
	dot = (x % 16 == 0) && (y % 16 == 0);
	if (x >= 640 || y >= 480) begin
		return color_black;
	end
	if (s.flag) begin
		return digit_pixel(x / 16, y / 16, s.score) ? color_digit : color_black;
	end
	// Food wins over whatever the game logic reports.
	if (x / 16 == int'(s.fx) && y / 16 == int'(s.fy)) begin
		return dot ? color_black : color_food;
	end
	case (s.snake)
		cell_head: return dot ? color_black : color_head;
		cell_body: return dot ? color_black : color_body;
		cell_wall: return color_wall;
		default: return color_black;
	endcase
endfunction

function automatic bit sync_level(input sample_t s, input bit vertical);
	return vertical ? s.vsync : s.hsync;
endfunction

task automatic capture();
	cur.valid = 1'b1;
	cur.x = pos_x;
	cur.y = pos_y;
	cur.hsync = hsync;
	cur.vsync = vsync;
	cur.rgb = rgb;
	cur.flag = score_flag;
	cur.snake = snake;
	cur.fx = food_x;
	cur.fy = food_y;
	cur.score = score;
endtask

// Drive at the rising edge and check at the falling edge.
task automatic tick();
	int h;
	int v;
	@(posedge clk);
	score <= nxt.score;
	score_flag <= nxt.flag;
	snake <= nxt.snake;
	food_x <= nxt.fx;
	food_y <= nxt.fy;
	@(negedge clk);
	prev = cur;
	capture();
	if (prev.valid) begin
		h = (int'(prev.x) + 135) % 1024;
		v = (int'(prev.y) + 33) % 1024;
		if (h == 799) begin
			v = (v + 1) % 525;
		end
		h = (h + 1) % 800;
		check("pos_x", int'(cur.x), (h + 1024 - 135) % 1024);
		check("pos_y", int'(cur.y), (v + 1024 - 33) % 1024);
		check("hsync", int'(cur.hsync), int'(h >= 96));
		check("vsync", int'(cur.vsync), int'(v >= 2));
		check("rgb", int'(cur.rgb), int'(expected_rgb(prev)));
	end
endtask

task automatic reset_test();
	repeat (5) begin
		@(posedge clk);
	end
	rst <= 1'b1;
	@(negedge clk);
	check("hsync", int'(hsync), 1);
	check("vsync", int'(vsync), 1);
	check("rgb", int'(rgb), int'(color_black));
	check("pos_x", int'(pos_x), 0);
	check("pos_y", int'(pos_y), 0);
	capture();
	cur.valid = 1'b0;
	prev = '0;
endtask

// Pulse width and period between two falling edges.
task automatic measure_sync(input bit vertical, input int low_exp, input int period_exp,
	input int periods, input string name);
	int low;
	int len;
	int rises;
	while (!(sync_level(prev, vertical) && !sync_level(cur, vertical))) begin
		tick();
	end
	repeat (periods) begin
		low = 0;
		len = 0;
		rises = 0;
		do begin
			if (!sync_level(cur, vertical)) begin
				low++;
			end
			len++;
			tick();
			if (!sync_level(prev, vertical) && sync_level(cur, vertical)) begin
				rises++;
			end
		end while (!(sync_level(prev, vertical) && !sync_level(cur, vertical)));
		check({name, " low cycles"}, low, low_exp);
		check({name, " rising edges"}, rises, 1);
		check({name, " period"}, len, period_exp);
	end
endtask

task automatic playfield_test();
	int food_px;
	food_px = 0;
	nxt.flag = 1'b0;
	repeat (frame_cycles) begin
		nxt.snake = cell_e'($urandom_range(3, 0));
		// New food tile during horizontal blanking.
		// Half the time it lands on the coming row.
		if (cur.x == 10'd650) begin
			nxt.fx = tile_x_t'($urandom_range(39, 0));
			if ($urandom_range(1, 0) == 1) begin
				nxt.fy = tile_y_t'((int'(cur.y) + 1) / 16);
			end else begin
				nxt.fy = tile_y_t'($urandom_range(29, 0));
			end
		end
		tick();
		if (expected_rgb(prev) == color_food) begin
			food_px++;
		end
	end
	check("food pixels seen", int'(food_px > 0), 1);
endtask

task automatic score_test();
	int digit_px;
	digit_px = 0;
	nxt.flag = 1'b1;
	repeat (frame_cycles) begin
		if (cur.x == 10'd650) begin
			nxt.score.hundreds = 4'($urandom_range(9, 0));
			nxt.score.tens = 4'($urandom_range(9, 0));
			nxt.score.units = ($urandom_range(7, 0) == 0) ? 4'hc : 4'($urandom_range(9, 0));
		end
		tick();
		if (expected_rgb(prev) == color_digit) begin
			digit_px++;
		end
	end
	check("digit pixels seen", int'(digit_px > 0), 1);
endtask

task automatic mode_change_test();
	int i;
	int toggles_seen;
	logic old_flag;
	sample_t flipped;
	toggles_seen = 0;
	nxt.snake = cell_wall;
	nxt.score = 12'h888;
	nxt.flag = 1'b0;
	while (!(cur.y == 10'd200 && cur.x == 10'd0)) begin
		tick();
	end
	for (i = 0; i < 2 * line_cycles; i++) begin
		// An odd period spreads the toggles over the columns.
		if (i % 37 == 0) begin
			nxt.flag = !nxt.flag;
		end
		old_flag = prev.flag;
		tick();
		// First rgb after a toggle on a pixel where the two modes differ.
		flipped = prev;
		flipped.flag = old_flag;
		if (prev.flag != old_flag && expected_rgb(flipped) != expected_rgb(prev)) begin
			toggles_seen++;
		end
	end
	check("mode toggles on differing pixels", int'(toggles_seen > 0), 1);
endtask

// ==== sim/tb_snake_vga.sv ====
`timescale 1ns/1ps

module tb_snake_vga;
	import snake_vga_pkg::*;

	localparam int line_cycles = 800;
	localparam int frame_cycles = 800 * 525;
	// Sync alignment and the mode test may each wait up to one frame.
	localparam int max_cycles = 5 * frame_cycles + 10 * line_cycles;

	// DUT view at a falling edge.
	typedef struct packed {
		logic valid;
		logic [9:0] x;
		logic [9:0] y;
		logic hsync;
		logic vsync;
		rgb565_t rgb;
		logic flag;
		cell_e snake;
		tile_x_t fx;
		tile_y_t fy;
		score_t score;
	} sample_t;

	// Input values applied at the next rising edge.
	typedef struct packed {
		logic flag;
		cell_e snake;
		tile_x_t fx;
		tile_y_t fy;
		score_t score;
	} drive_t;

	logic clk;
	logic rst;
	score_t score;
	logic score_flag;
	cell_e snake;
	tile_x_t food_x;
	tile_y_t food_y;
	logic [9:0] pos_x;
	logic [9:0] pos_y;
	logic hsync;
	logic vsync;
	rgb565_t rgb;

	sample_t cur;
	sample_t prev;
	drive_t nxt;
	int cycle_count = 0;

	snake_vga i_dut (
		.clk(clk),
		.rst(rst),
		.score(score),
		.score_flag(score_flag),
		.snake(snake),
		.food_x(food_x),
		.food_y(food_y),
		.pos_x(pos_x),
		.pos_y(pos_y),
		.hsync(hsync),
		.vsync(vsync),
		.rgb(rgb)
	);

	`include "tb_snake_vga_tasks.svh"

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == max_cycles) begin
			$display("Timeout: the tests did not finish within %0d cycles", max_cycles);
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	end

	initial begin
		void'($urandom(32'h8411_8561));
		rst = 1'b0;
		score = '0;
		score_flag = 1'b0;
		snake = cell_empty;
		food_x = '0;
		food_y = '0;
		nxt = '0;
		reset_test();
		measure_sync(1'b0, 96, line_cycles, 3, "hsync");
		measure_sync(1'b1, 2 * line_cycles, frame_cycles, 1, "vsync");
		playfield_test();
		score_test();
		mode_change_test();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// ==== snake_vga.f ====
design/snake_vga_pkg.sv
design/vga_timing.sv
design/cell_renderer.sv
design/digit_segments.sv
design/score_renderer.sv
design/pixel_composer.sv
design/snake_vga.sv
+incdir+sim
sim/tb_snake_vga.sv

// ==== Makefile ====
# Verilator build and run of the snake VGA testbench.

VERILATOR ?= verilator
TOP       ?= tb_snake_vga
FILELIST  ?= snake_vga.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

PASS_MSG := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
